//--- verilog.f
tpu_pkg.sv
pe.sv
control_unit.sv
weight_memory.sv
unified_buffer.sv
input_setup.sv
mmu.sv
accumulator.sv
tpu_top.sv
tpu_sva.sv
tpu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the TPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tpu_tb -o tpu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tpu_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx 'ALL CHECKS PASSED'; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- tpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module tpu_tb;
  import tpu_pkg::*;

  localparam int max_programs_c       = 40;
  localparam int cycles_per_program_c = 64;
  localparam int cycle_limit_c        = max_programs_c * cycles_per_program_c + 200;
  localparam int random_programs_c    = 8;

  logic       clk;
  logic       reset;
  logic       start;
  logic       prog_we;
  prog_addr_t prog_addr;
  instr_t     prog_data;
  logic       wmem_we;
  mem_addr_t  wmem_addr;
  data_t      wmem_data;
  logic       ub_we;
  mem_addr_t  ub_addr;
  acc_t       ub_wdata;
  acc_t       ub_rdata;
  logic       busy;
  logic       done;

  // Reference model state
  data_t       wmem_model [mem_depth_c];
  acc_t        ub_model [mem_depth_c];
  data_t       w_lat [4];    // w11 w12 w21 w22 held in the array
  data_t       a_lat [4];    // a11 a12 a21 a22
  acc_t        c_lat [4];    // c11 c12 c21 c22 held by the accumulators
  mem_addr_t   base_model;   // Survives start and is cleared by reset only
  instr_t      prog [prog_depth_c];
  mem_addr_t   store_bases [$];
  mem_addr_t   spots [16];
  mem_addr_t   wb, ib, sb;

  int unsigned lcg_state;
  int          cycle_cnt = 0;
  int          checks = 0;
  int          errors = 0;
  int          test_start = 0;
  logic [2:0]  code;

  tpu_top tpu_top_i (
    .clk(clk), .reset(reset), .start(start),
    .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
    .wmem_we(wmem_we), .wmem_addr(wmem_addr), .wmem_data(wmem_data),
    .ub_we(ub_we), .ub_addr(ub_addr), .ub_wdata(ub_wdata), .ub_rdata(ub_rdata),
    .busy(busy), .done(done)
  );

  bind tpu_top tpu_sva tpu_sva_i (
    .clk(clk), .reset(reset), .load_weight(load_weight), .load_input(load_input),
    .store(store), .valid(valid), .busy(busy), .done(done),
    .prog_we(prog_we), .wmem_we(wmem_we), .ub_we(ub_we),
    .full1(full1), .full2(full2)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // Run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit_c) begin
      $display("Timeout: simulation ran past %0d cycles without finishing", cycle_limit_c);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic mem_addr_t rand_addr();
    return mem_addr_t'(next_random() >> 26);  // Upper bits spread better
  endfunction

  function automatic data_t rand_data();
    return data_t'(next_random() >> 16);
  endfunction

  function automatic mem_addr_t wrap_addr(input mem_addr_t b, input int k);
    return mem_addr_t'(int'(b) + k);  // Modulo 64
  endfunction

  // Opcode on top and random junk above the 6 address bits
  function automatic instr_t encode(input logic [2:0] op, input mem_addr_t addr);
    return {op, 7'(next_random() >> 25), addr};
  endfunction

  function automatic acc_t dot2(input data_t a1, input data_t w1, input data_t a2,
                                input data_t w2);
    return acc_t'(a1) * acc_t'(w1) + acc_t'(a2) * acc_t'(w2);  // Wraps mod 2^32
  endfunction

  task automatic check_acc(input string name, input acc_t got, input acc_t expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Error at %0t: %s = %h, expected %h", $time, name, got, expected);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("Error at %0t: %s = %b, expected %b", $time, name, got, expected);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    base_model = '0;
    for (int k = 0; k < 4; k++) begin
      w_lat[k] = '0;
      a_lat[k] = '0;
      c_lat[k] = '0;  // STORE before COMPUTE gives zeros
    end
  endtask

  task automatic write_wmem(input mem_addr_t addr, input data_t data);
    @(posedge clk);
    prog_we   <= 1'b0;
    ub_we     <= 1'b0;
    wmem_we   <= 1'b1;
    wmem_addr <= addr;
    wmem_data <= data;
    wmem_model[addr] = data;
  endtask

  task automatic write_ub(input mem_addr_t addr, input acc_t data);
    @(posedge clk);
    prog_we  <= 1'b0;
    wmem_we  <= 1'b0;
    ub_we    <= 1'b1;
    ub_addr  <= addr;
    ub_wdata <= data;
    ub_model[addr] = data;
  endtask

  task automatic end_writes();
    @(posedge clk);
    prog_we <= 1'b0;
    wmem_we <= 1'b0;
    ub_we   <= 1'b0;
  endtask

  // Four weights and four activation words that both wrap
  task automatic write_tile(input mem_addr_t wbase, input mem_addr_t ibase);
    for (int k = 0; k < 4; k++)
      write_wmem(wrap_addr(wbase, k), rand_data());
    for (int k = 0; k < 4; k++)
      write_ub(wrap_addr(ibase, k), next_random());
    end_writes();
  endtask

  task automatic read_check_ub(input mem_addr_t addr);
    @(posedge clk);
    ub_addr <= addr;
    @(negedge clk);  // Combinational read settled
    check_acc($sformatf("ub_rdata[%0d]", addr), ub_rdata, ub_model[addr]);
  endtask

  // Step through the program slot by slot in the reference model
  task automatic model_program();
    logic     ended;
    operand_t operand;
    ended = 1'b0;
    store_bases.delete();
    for (int s = 0; s < prog_depth_c && !ended; s++) begin
      code    = prog[s][instr_w_c-1 -: opcode_w_c];
      operand = prog[s][operand_w_c-1:0];
      case (code)
        op_nop:       ended = 1'b1;
        op_load_addr: base_model = operand[mem_addr_w_c-1:0];
        op_load_weight: begin
          for (int k = 0; k < 4; k++)
            w_lat[k] = wmem_model[wrap_addr(base_model, k)];
        end
        op_load_input: begin
          for (int k = 0; k < 4; k++)
            a_lat[k] = ub_model[wrap_addr(base_model, k)][data_w_c-1:0];
        end
        op_compute: begin  // c_ij = a_i1*w_1j + a_i2*w_2j
          c_lat[0] = dot2(a_lat[0], w_lat[0], a_lat[1], w_lat[2]);
          c_lat[1] = dot2(a_lat[0], w_lat[1], a_lat[1], w_lat[3]);
          c_lat[2] = dot2(a_lat[2], w_lat[0], a_lat[3], w_lat[2]);
          c_lat[3] = dot2(a_lat[2], w_lat[1], a_lat[3], w_lat[3]);
        end
        op_store: begin
          for (int k = 0; k < 4; k++)
            ub_model[wrap_addr(base_model, k)] = c_lat[k];
          store_bases.push_back(base_model);
        end
        default: ;  // 6 and 7 skipped
      endcase
    end
  endtask

  // Stored words plus one neighbour on each side
  task automatic check_stores();
    foreach (store_bases[i]) begin
      for (int k = -1; k <= 4; k++)
        read_check_ub(wrap_addr(store_bases[i], k));
    end
  endtask

  task automatic run_program();
    for (int s = 0; s < prog_depth_c; s++) begin
      @(posedge clk);
      wmem_we   <= 1'b0;
      ub_we     <= 1'b0;
      prog_we   <= 1'b1;
      prog_addr <= prog_addr_t'(s);
      prog_data <= prog[s];
    end
    end_writes();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    @(negedge clk);
    check_flag("done", done, 1'b0);  // Cleared by start
    check_flag("busy", busy, 1'b1);
    while (!done)
      @(negedge clk);
    check_flag("busy", busy, 1'b0);
    model_program();
    check_stores();
  endtask

  task automatic report_test(input int num, input string name);
    $display("Test %0d %s: %0d errors", num, name, errors - test_start);
    test_start = errors;
  endtask

  initial begin
    lcg_state = 32'h5a5a_1bc1;
    reset     = 1'b1;
    start     = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    wmem_we   = 1'b0;
    wmem_addr = '0;
    wmem_data = '0;
    ub_we     = 1'b0;
    ub_addr   = '0;
    ub_wdata  = '0;
    apply_reset();

    // Test 1 checks reset levels and the host buffer port
    @(negedge clk);
    check_flag("busy", busy, 1'b0);
    check_flag("done", done, 1'b0);
    for (int k = 0; k < mem_depth_c; k++) begin
      write_wmem(mem_addr_t'(k), rand_data());
      write_ub(mem_addr_t'(k), next_random());
    end
    for (int k = 0; k < 16; k++) begin
      spots[k] = rand_addr();
      write_ub(spots[k], next_random());
    end
    end_writes();
    for (int k = 0; k < 16; k++)
      read_check_ub(spots[k]);
    report_test(1, "reset and host buffer access");

    // Test 2 runs one full matrix product
    wb = rand_addr();
    ib = rand_addr();
    sb = rand_addr();
    write_tile(wb, ib);
    prog[0] = encode(op_load_addr, wb);
    prog[1] = encode(op_load_weight, rand_addr());
    prog[2] = encode(op_load_addr, ib);
    prog[3] = encode(op_load_input, rand_addr());
    prog[4] = encode(op_compute, rand_addr());
    prog[5] = encode(op_load_addr, sb);
    prog[6] = encode(op_store, rand_addr());
    prog[7] = encode(op_nop, rand_addr());
    run_program();
    report_test(2, "single matrix product");

    // Test 3 runs two pairs without END and then a tile across word 63
    sb = mem_addr_t'(8 + (next_random() >> 27));
    write_tile(rand_addr(), 6'd62);
    write_tile(rand_addr(), sb);
    prog[0] = encode(op_load_addr, 6'd62);
    prog[1] = encode(op_load_input, rand_addr());
    prog[2] = encode(op_compute, rand_addr());
    prog[3] = encode(op_store, rand_addr());
    prog[4] = encode(op_load_addr, sb);
    prog[5] = encode(op_load_input, rand_addr());
    prog[6] = encode(op_compute, rand_addr());
    prog[7] = encode(op_store, rand_addr());
    run_program();
    write_tile(6'd63, 6'd61);
    prog[0] = encode(op_load_addr, 6'd63);
    prog[1] = encode(op_load_weight, rand_addr());
    prog[2] = encode(op_load_addr, 6'd61);
    prog[3] = encode(op_load_input, rand_addr());
    prog[4] = encode(op_compute, rand_addr());
    prog[5] = encode(op_load_addr, 6'd63);
    prog[6] = encode(op_store, rand_addr());
    prog[7] = encode(op_nop, rand_addr());
    run_program();
    report_test(3, "two products and address wrap");

    // Test 4 covers a fresh reset, undefined codes and a STORE with nothing computed
    apply_reset();
    @(negedge clk);
    check_flag("busy", busy, 1'b0);
    check_flag("done", done, 1'b0);
    prog[0] = encode(3'd6, rand_addr());
    prog[1] = encode(op_store, rand_addr());  // Base still 0 after reset
    prog[2] = encode(3'd7, rand_addr());
    prog[3] = encode(op_load_addr, rand_addr());
    prog[4] = encode(op_store, rand_addr());
    prog[5] = encode(3'd6, rand_addr());
    prog[6] = encode(3'd7, rand_addr());
    prog[7] = encode(3'd6, rand_addr());
    run_program();
    check_flag("done", done, 1'b1);
    report_test(4, "undefined opcodes and missing END");

    // Test 5 runs back-to-back random programs
    for (int p = 0; p < random_programs_c; p++) begin
      write_tile(rand_addr(), rand_addr());
      for (int s = 0; s < prog_depth_c; s++) begin
        code = 3'(next_random() >> 29);
        if (code == 3'd0 && s < 5)
          code = op_compute;  // Keep most programs long
        prog[s] = encode(code, rand_addr());
      end
      run_program();
    end
    report_test(5, "random programs after restart");

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tpu_sva.sv
`timescale 1ns/10ps
`default_nettype none

module tpu_sva (
  input logic clk,
  input logic reset,
  input logic load_weight,
  input logic load_input,
  input logic store,
  input logic valid,
  input logic busy,
  input logic done,
  input logic prog_we,
  input logic wmem_we,
  input logic ub_we,
  input logic full1,
  input logic full2
);

  logic [3:0] valid_run_q;  // Consecutive valid cycles up to the last edge

  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      valid_run_q <= '0;
    else if (valid)
      valid_run_q <= valid_run_q + 4'd1;
    else
      valid_run_q <= '0;  // Run broken
  end

  // Strobes and the compute level are mutually exclusive
  one_strobe_a: assert property (@(posedge clk) disable iff (reset)
    $onehot0({load_weight, load_input, store, valid}))
    else $error("More than one control strobe high in one cycle");

  // A COMPUTE run never grows past six cycles
  valid_max_a: assert property (@(posedge clk) disable iff (reset)
    valid |-> (valid_run_q < 4'd6))
    else $error("valid held longer than six cycles");

  valid_min_a: assert property (@(posedge clk) disable iff (reset)
    (!valid && valid_run_q != 4'd0) |-> (valid_run_q == 4'd6))
    else $error("valid dropped before six cycles");

  // Both columns hold their two results by the last compute cycle
  results_full_a: assert property (@(posedge clk) disable iff (reset)
    (valid && valid_run_q == 4'd5) |-> (full1 && full2))
    else $error("Accumulators not full in the last compute cycle");

  host_idle_a: assert property (@(posedge clk) disable iff (reset)
    busy |-> !(prog_we || wmem_we || ub_we))
    else $error("Host write while busy");

  busy_done_a: assert property (@(posedge clk) disable iff (reset)
    !(busy && done))
    else $error("busy and done high together");

endmodule

`default_nettype wire

//--- tpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module tpu_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  logic                prog_we,
  input  tpu_pkg::prog_addr_t prog_addr,
  input  tpu_pkg::instr_t     prog_data,
  input  logic                wmem_we,
  input  tpu_pkg::mem_addr_t  wmem_addr,
  input  tpu_pkg::data_t      wmem_data,
  input  logic                ub_we,
  input  tpu_pkg::mem_addr_t  ub_addr,
  input  tpu_pkg::acc_t       ub_wdata,
  output tpu_pkg::acc_t       ub_rdata,
  output logic                busy,
  output logic                done
);
  import tpu_pkg::*;

  mem_addr_t base_addr;
  logic      load_weight, load_input, store;
  logic      valid, compute_start;
  data_t     w11, w12, w21, w22;    // Weight tile
  data_t     a11, a12, a21, a22;    // Activation tile
  data_t     a_in1, a_in2;          // Skewed rows into the array
  acc_t      acc_out1, acc_out2;
  logic      out_valid1, out_valid2;
  acc_t      c11, c12, c21, c22;    // Result tile
  logic      full1, full2;          // Column results complete

  control_unit control_unit_i (
    .clk(clk), .reset(reset), .start(start),
    .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
    .base_addr(base_addr), .load_weight(load_weight), .load_input(load_input),
    .store(store), .valid(valid), .compute_start(compute_start),
    .busy(busy), .done(done)
  );

  weight_memory weight_memory_i (
    .clk(clk), .wmem_we(wmem_we), .wmem_addr(wmem_addr), .wmem_data(wmem_data),
    .base_addr(base_addr), .w11(w11), .w12(w12), .w21(w21), .w22(w22)
  );

  unified_buffer unified_buffer_i (
    .clk(clk), .reset(reset),
    .ub_we(ub_we), .ub_addr(ub_addr), .ub_wdata(ub_wdata), .ub_rdata(ub_rdata),
    .base_addr(base_addr), .load_input(load_input), .store(store),
    .c11(c11), .c12(c12), .c21(c21), .c22(c22),
    .a11(a11), .a12(a12), .a21(a21), .a22(a22)
  );

  input_setup input_setup_i (
    .clk(clk), .reset(reset), .valid(valid), .compute_start(compute_start),
    .a11(a11), .a12(a12), .a21(a21), .a22(a22), .a_in1(a_in1), .a_in2(a_in2)
  );

  mmu mmu_i (
    .clk(clk), .reset(reset), .load_weight(load_weight), .valid(valid),
    .a_in1(a_in1), .a_in2(a_in2), .w11(w11), .w12(w12), .w21(w21), .w22(w22),
    .acc_out1(acc_out1), .acc_out2(acc_out2),
    .out_valid1(out_valid1), .out_valid2(out_valid2)
  );

  // Column 1 yields c11 then c21, column 2 c12 then c22
  accumulator acc1_i (
    .clk(clk), .reset(reset), .compute_start(compute_start), .out_valid(out_valid1),
    .acc_in(acc_out1), .acc_mem_0(c11), .acc_mem_1(c21), .full(full1)
  );

  accumulator acc2_i (
    .clk(clk), .reset(reset), .compute_start(compute_start), .out_valid(out_valid2),
    .acc_in(acc_out2), .acc_mem_0(c12), .acc_mem_1(c22), .full(full2)
  );

endmodule

`default_nettype wire

//--- accumulator.sv
`timescale 1ns/10ps
`default_nettype none

module accumulator (
  input  logic          clk,
  input  logic          reset,
  input  logic          compute_start,
  input  logic          out_valid,
  input  tpu_pkg::acc_t acc_in,
  output tpu_pkg::acc_t acc_mem_0,  // Row 1 result of this column
  output tpu_pkg::acc_t acc_mem_1,  // Row 2 result
  output logic          full
);

  logic [1:0] slot_q;  // Results held so far

  assign full = (slot_q == 2'd2);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      slot_q    <= '0;
      acc_mem_0 <= '0;  // STORE before COMPUTE sees zeros
      acc_mem_1 <= '0;
    end else if (compute_start) begin
      slot_q <= '0;  // Old results stay until overwritten
    end else if (out_valid && !full) begin
      if (slot_q == 2'd0)
        acc_mem_0 <= acc_in;
      else
        acc_mem_1 <= acc_in;
      slot_q <= slot_q + 2'd1;
    end
  end

endmodule

`default_nettype wire

//--- mmu.sv
`timescale 1ns/10ps
`default_nettype none

module mmu (
  input  logic           clk,
  input  logic           reset,
  input  logic           load_weight,
  input  logic           valid,
  input  tpu_pkg::data_t a_in1,
  input  tpu_pkg::data_t a_in2,
  input  tpu_pkg::data_t w11,
  input  tpu_pkg::data_t w12,
  input  tpu_pkg::data_t w21,
  input  tpu_pkg::data_t w22,
  output tpu_pkg::acc_t  acc_out1,  // Column 1 bottom
  output tpu_pkg::acc_t  acc_out2,  // Column 2 bottom
  output logic           out_valid1,
  output logic           out_valid2
);
  import tpu_pkg::*;

  data_t      act_r1;     // Row 1 activation moving right
  data_t      act_r2;     // Row 2 activation moving right
  acc_t       psum_c2;    // Column 2 partial sum moving down
  acc_t       psum_c1;
  logic       valid_q;
  logic       head;       // First cycle of a COMPUTE
  logic [3:0] head_sr;    // head delayed by 1..4 cycles

  // Cell kj holds weight w_kj; row k carries a_ik
  pe pe11 (.clk(clk), .reset(reset), .load_weight(load_weight), .weight_in(w11),
           .act_in(a_in1), .sum_in(acc_t'(0)), .act_out(act_r1), .sum_out(psum_c1));
  pe pe12 (.clk(clk), .reset(reset), .load_weight(load_weight), .weight_in(w12),
           .act_in(act_r1), .sum_in(acc_t'(0)), .act_out(), .sum_out(psum_c2));
  pe pe21 (.clk(clk), .reset(reset), .load_weight(load_weight), .weight_in(w21),
           .act_in(a_in2), .sum_in(psum_c1), .act_out(act_r2), .sum_out(acc_out1));
  pe pe22 (.clk(clk), .reset(reset), .load_weight(load_weight), .weight_in(w22),
           .act_in(act_r2), .sum_in(psum_c2), .act_out(), .sum_out(acc_out2));

  assign head = valid && !valid_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      valid_q <= 1'b0;
      head_sr <= '0;
    end else begin
      valid_q <= valid;
      head_sr <= {head_sr[2:0], head};
    end
  end

  // Two results per column, column 2 one cycle behind
  assign out_valid1 = head_sr[1] || head_sr[2];
  assign out_valid2 = head_sr[2] || head_sr[3];

endmodule

`default_nettype wire

//--- input_setup.sv
`timescale 1ns/10ps
`default_nettype none

module input_setup (
  input  logic           clk,
  input  logic           reset,
  input  logic           valid,
  input  logic           compute_start,
  input  tpu_pkg::data_t a11,
  input  tpu_pkg::data_t a12,
  input  tpu_pkg::data_t a21,
  input  tpu_pkg::data_t a22,
  output tpu_pkg::data_t a_in1,  // Row 1 of the array
  output tpu_pkg::data_t a_in2   // Row 2, one cycle behind
);

  logic [1:0] step_q;  // Cycles since compute_start, sticks at 3

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      step_q <= '0;
    end else if (compute_start) begin
      step_q <= 2'd1;
    end else if (!valid) begin
      step_q <= '0;  // Idle between computes
    end else if (step_q != 2'd0 && step_q != 2'd3) begin
      step_q <= step_q + 2'd1;
    end
  end

  // Skewed feed, zeros outside the stream
  always_comb begin
    a_in1 = '0;
    a_in2 = '0;
    if (valid) begin
      if (compute_start) begin
        a_in1 = a11;
      end else if (step_q == 2'd1) begin
        a_in1 = a21;
        a_in2 = a12;
      end else if (step_q == 2'd2) begin
        a_in2 = a22;
      end
    end
  end

endmodule

`default_nettype wire

//--- unified_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module unified_buffer (
  input  logic               clk,
  input  logic               reset,
  input  logic               ub_we,
  input  tpu_pkg::mem_addr_t ub_addr,
  input  tpu_pkg::acc_t      ub_wdata,
  output tpu_pkg::acc_t      ub_rdata,
  input  tpu_pkg::mem_addr_t base_addr,
  input  logic               load_input,
  input  logic               store,
  input  tpu_pkg::acc_t      c11,
  input  tpu_pkg::acc_t      c12,
  input  tpu_pkg::acc_t      c21,
  input  tpu_pkg::acc_t      c22,
  output tpu_pkg::data_t     a11,
  output tpu_pkg::data_t     a12,
  output tpu_pkg::data_t     a21,
  output tpu_pkg::data_t     a22
);
  import tpu_pkg::*;

  acc_t      mem [mem_depth_c];
  mem_addr_t word_addr [4];  // Shared by activation read and result write

  always_comb begin
    for (int k = 0; k < 4; k++) begin
      word_addr[k] = base_addr + mem_addr_t'(k);  // Wraps past word 63
    end
  end

  // Host write first, store port overrides on a clash
  always_ff @(posedge clk) begin
    if (ub_we)
      mem[ub_addr] <= ub_wdata;
    if (store) begin
      mem[word_addr[0]] <= c11;
      mem[word_addr[1]] <= c12;
      mem[word_addr[2]] <= c21;
      mem[word_addr[3]] <= c22;
    end
  end

  assign ub_rdata = mem[ub_addr];  // Combinational host read

  // Activation tile, low half of each word
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      a11 <= '0;
      a12 <= '0;
      a21 <= '0;
      a22 <= '0;
    end else if (load_input) begin
      a11 <= mem[word_addr[0]][data_w_c-1:0];
      a12 <= mem[word_addr[1]][data_w_c-1:0];
      a21 <= mem[word_addr[2]][data_w_c-1:0];
      a22 <= mem[word_addr[3]][data_w_c-1:0];
    end
  end

endmodule

`default_nettype wire

//--- weight_memory.sv
`timescale 1ns/10ps
`default_nettype none

module weight_memory (
  input  logic               clk,
  input  logic               wmem_we,
  input  tpu_pkg::mem_addr_t wmem_addr,
  input  tpu_pkg::data_t     wmem_data,
  input  tpu_pkg::mem_addr_t base_addr,
  output tpu_pkg::data_t     w11,
  output tpu_pkg::data_t     w12,
  output tpu_pkg::data_t     w21,
  output tpu_pkg::data_t     w22
);
  import tpu_pkg::*;

  data_t     mem [mem_depth_c];
  mem_addr_t rd_addr [4];  // Four consecutive words from base

  // Host write port
  always_ff @(posedge clk) begin
    if (wmem_we)
      mem[wmem_addr] <= wmem_data;
  end

  always_comb begin
    for (int k = 0; k < 4; k++) begin
      rd_addr[k] = base_addr + mem_addr_t'(k);  // 6-bit add wraps at 64
    end
  end

  // Row-major 2x2 weight tile
  assign w11 = mem[rd_addr[0]];
  assign w12 = mem[rd_addr[1]];
  assign w21 = mem[rd_addr[2]];
  assign w22 = mem[rd_addr[3]];

endmodule

`default_nettype wire

//--- control_unit.sv
`timescale 1ns/10ps
`default_nettype none

module control_unit (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,          // One-cycle pulse from host
  input  logic                prog_we,
  input  tpu_pkg::prog_addr_t prog_addr,
  input  tpu_pkg::instr_t     prog_data,
  output tpu_pkg::mem_addr_t  base_addr,
  output logic                load_weight,
  output logic                load_input,
  output logic                store,
  output logic                valid,          // Level over all COMPUTE cycles
  output logic                compute_start,  // First COMPUTE cycle only
  output logic                busy,
  output logic                done
);
  import tpu_pkg::*;

  instr_t      prog_mem [prog_depth_c];  // Host-loaded program
  instr_t      instr_q;                  // Instruction being executed
  prog_addr_t  ip_q;                     // Instruction pointer
  ctrl_state_e state_q;
  logic [2:0]  cnt_q;                    // Cycles spent in current COMPUTE
  mem_addr_t   base_q;
  opcode_e     opcode;
  operand_t    operand;
  logic        in_exec;
  logic        last_slot;
  logic        compute_hold;

  // Host program port
  always_ff @(posedge clk) begin
    if (prog_we)
      prog_mem[prog_addr] <= prog_data;
  end

  // Instruction register loaded in fetch
  always_ff @(posedge clk) begin
    if (state_q == fetch)
      instr_q <= prog_mem[ip_q];
  end

  assign opcode    = opcode_e'(instr_q[instr_w_c-1 -: opcode_w_c]);  // Codes 6 and 7 match no strobe
  assign operand   = instr_q[operand_w_c-1:0];
  assign in_exec   = (state_q == execute);
  assign last_slot = (ip_q == prog_addr_t'(prog_depth_c - 1));

  // COMPUTE stays in execute until its last cycle
  assign compute_hold = (opcode == op_compute) && (cnt_q != 3'(compute_cycles_c - 1));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state_q <= idle;
      ip_q    <= '0;
      cnt_q   <= '0;
      base_q  <= '0;
    end else begin
      case (state_q)
        idle, finish: begin
          if (start) begin  // Restart always at slot 0
            state_q <= fetch;
            ip_q    <= '0;
            cnt_q   <= '0;
          end
        end
        fetch: state_q <= execute;
        execute: begin
          if (compute_hold) begin
            cnt_q <= cnt_q + 3'd1;
          end else begin
            cnt_q <= '0;
            if (opcode == op_load_addr)
              base_q <= operand[mem_addr_w_c-1:0];  // Takes effect after this cycle
            if (opcode == op_nop || last_slot) begin
              state_q <= finish;  // END or ran off the last slot
            end else begin
              ip_q    <= ip_q + prog_addr_t'(1);
              state_q <= fetch;
            end
          end
        end
        default: state_q <= idle;
      endcase
    end
  end

  // Strobes are decoded straight from the executing opcode
  assign load_weight   = in_exec && (opcode == op_load_weight);
  assign load_input    = in_exec && (opcode == op_load_input);
  assign store         = in_exec && (opcode == op_store);
  assign valid         = in_exec && (opcode == op_compute);
  assign compute_start = valid && (cnt_q == '0);

  assign busy      = (state_q == fetch) || (state_q == execute);
  assign done      = (state_q == finish);  // Held until next start
  assign base_addr = base_q;

endmodule

`default_nettype wire

//--- pe.sv
`timescale 1ns/10ps
`default_nettype none

module pe (
  input  logic           clk,
  input  logic           reset,
  input  logic           load_weight,
  input  tpu_pkg::data_t weight_in,
  input  tpu_pkg::data_t act_in,
  input  tpu_pkg::acc_t  sum_in,   // Partial sum from the cell above
  output tpu_pkg::data_t act_out,  // To the cell on the right
  output tpu_pkg::acc_t  sum_out   // To the cell below
);
  import tpu_pkg::*;

  data_t weight_q;  // Stationary weight
  acc_t  product;

  assign product = acc_t'(act_in) * acc_t'(weight_q);  // Full 32-bit product

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      weight_q <= '0;
      act_out  <= '0;
      sum_out  <= '0;
    end else begin
      if (load_weight)
        weight_q <= weight_in;
      act_out <= act_in;
      sum_out <= sum_in + product;  // Wraps mod 2^32
    end
  end

endmodule

`default_nettype wire

//--- tpu_pkg.sv
`default_nettype none

package tpu_pkg;

  // Field and word widths
  localparam int data_w_c      = 16;  // Weight or activation
  localparam int acc_w_c       = 32;  // Product sum, buffer word
  localparam int instr_w_c     = 16;
  localparam int opcode_w_c    = 3;   // Top bits of an instruction
  localparam int operand_w_c   = 13;  // Remaining low bits
  localparam int mem_addr_w_c  = 6;
  localparam int prog_addr_w_c = 3;

  // Depths and timing
  localparam int prog_depth_c     = 8;   // Program slots
  localparam int mem_depth_c      = 64;  // Weight memory and unified buffer
  localparam int compute_cycles_c = 6;   // Execute cycles held by one COMPUTE

  typedef logic [data_w_c-1:0]      data_t;
  typedef logic [acc_w_c-1:0]       acc_t;
  typedef logic [instr_w_c-1:0]     instr_t;     // {opcode, operand}
  typedef logic [operand_w_c-1:0]   operand_t;
  typedef logic [mem_addr_w_c-1:0]  mem_addr_t;  // Low operand bits
  typedef logic [prog_addr_w_c-1:0] prog_addr_t;

  // Codes 6 and 7 are left undefined and run as a no-op
  typedef enum logic [opcode_w_c-1:0] {
    op_nop         = 3'd0,  // END
    op_load_addr   = 3'd1,
    op_load_weight = 3'd2,
    op_load_input  = 3'd3,
    op_compute     = 3'd4,
    op_store       = 3'd5
  } opcode_e;

  typedef enum logic [1:0] {
    idle,
    fetch,
    execute,
    finish
  } ctrl_state_e;

endpackage

`default_nettype wire
